// ==== common/exu_params.svh ====
// data width, AXI address width and AXI response code macros
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

`define EXU_XLEN 64

`define EXU_AW 32

// AXI response codes
`define EXU_RESP_OKAY 2'b00

`endif

// ==== common/exu_pkg.sv ====
// operation enums, control/operand/request structs and the result record
`include "exu_params.svh"

package exu_pkg;

  typedef enum logic [4:0] {
    ALU_ADD    = 5'd0,
    ALU_SUB    = 5'd1,
    ALU_SLL    = 5'd2,
    ALU_SLT    = 5'd3,
    ALU_SLTU   = 5'd4,
    ALU_XOR    = 5'd5,
    ALU_SRL    = 5'd6,
    ALU_SRA    = 5'd7,
    ALU_OR     = 5'd8,
    ALU_AND    = 5'd9,
    ALU_COPY_B = 5'd10 // lui style pass of operand b
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC_B_RS2  = 2'b00,
    SRC_B_IMM  = 2'b01,
    SRC_B_FOUR = 2'b10
  } src_b_e;

  // low 3 bits as the jumper codes, bit 3 turns blt/bge unsigned
  typedef enum logic [3:0] {
    BR_NONE = 4'b0000,
    BR_JAL  = 4'b0001,
    BR_JALR = 4'b0010,
    BR_BEQ  = 4'b0100,
    BR_BNE  = 4'b0101,
    BR_BLT  = 4'b0110,
    BR_BGE  = 4'b0111,
    BR_BLTU = 4'b1110,
    BR_BGEU = 4'b1111
  } branch_e;

  typedef enum logic [2:0] {
    MEM_LB   = 3'b000,
    MEM_LBU  = 3'b001,
    MEM_LH   = 3'b010,
    MEM_LHU  = 3'b011,
    MEM_LW   = 3'b100,
    MEM_LWU  = 3'b101,
    MEM_LD   = 3'b110,
    MEM_NONE = 3'b111
  } mem_op_e;

  typedef enum logic [1:0] {
    CSR_NONE  = 2'b00,
    CSR_WRITE = 2'b01,
    CSR_SET   = 2'b10
  } csr_op_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    src_a_pc;
    src_b_e  src_b;
    logic    word_cut;
    branch_e branch;
    mem_op_e mem_op;
    logic    sel_csr;
    logic    sel_zimm;
    csr_op_e csr_op;
    logic    sys_change_pc;
    logic    ebreak;
    logic    illegal;
  } exu_ctrl_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0] rs1;
    logic [`EXU_XLEN-1:0] rs2;
    logic [`EXU_XLEN-1:0] imm;
    logic [`EXU_XLEN-1:0] pc;
    logic [`EXU_XLEN-1:0] sysctr_pc;
    logic [`EXU_XLEN-1:0] zimm;
  } exu_opnd_t;

  typedef struct packed {
    exu_ctrl_t            ctrl;
    exu_opnd_t            opnd;
    logic [`EXU_XLEN-1:0] csr_rdata;
  } exu_issue_t;

  typedef struct packed {
    logic [`EXU_XLEN-1:0] gpr_wdata;
    logic [`EXU_XLEN-1:0] next_pc;
    logic [`EXU_XLEN-1:0] csr_wdata;
    logic                 ebreak;
    logic                 illegal;
    logic                 load_err;
  } exu_res_t;

endpackage

// ==== common/exu_issue_if.sv ====
// issue interface from the input slice to the execute units
interface exu_issue_if;
  import exu_pkg::*;

  logic      valid;
  logic      ready;
  exu_ctrl_t ctrl;
  exu_opnd_t opnd;

  modport source (
    output valid, ctrl, opnd,
    input  ready
  );

  modport sink (
    input  valid, ctrl, opnd,
    output ready
  );

  // side-by-side units, no handshake role
  modport observe (
    input valid, ready, ctrl, opnd
  );

endinterface

// ==== hw/exu_pipe_reg.sv ====
// exu_pipe_reg: one-entry valid/ready register slice, payload type parameter
module exu_pipe_reg #(
  parameter type T = logic
) (
  input  logic i_clk,
  input  logic i_arst_n,
  input  logic i_valid,
  output logic o_ready,
  input  T     i_data,
  output logic o_valid,
  input  logic i_ready,
  output T     o_data
);

  logic full;
  T     data_q;

  // refill in the same cycle the held item leaves
  assign o_ready = !full || i_ready;
  assign o_valid = full;
  assign o_data  = data_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      full <= 1'b0;
    end else if (i_valid && o_ready) begin
      full <= 1'b1;
    end else if (i_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      data_q <= i_data;
    end
  end

endmodule

// ==== hw/exu_alu.sv ====
// exu_alu: 64-bit ALU with word cut, word result extension and zero/less flags
`include "exu_params.svh"

module exu_alu (
  exu_issue_if.observe         i_iss,
  output logic [`EXU_XLEN-1:0] o_result,
  output logic                 o_zero,
  output logic                 o_less
);
  import exu_pkg::*;

  logic [`EXU_XLEN-1:0] rs1_c;
  logic [`EXU_XLEN-1:0] rs2_c;
  logic [`EXU_XLEN-1:0] imm_c;
  logic [`EXU_XLEN-1:0] src_a;
  logic [`EXU_XLEN-1:0] src_b;
  logic [`EXU_XLEN-1:0] diff;
  logic [`EXU_XLEN-1:0] a_sra;
  logic [`EXU_XLEN-1:0] res;
  logic [5:0]           shamt;
  logic                 word;

  assign word = i_iss.ctrl.word_cut;

  // word ops: operands zero extended from 32 bits
  assign rs1_c = word ? {{(`EXU_XLEN-32){1'b0}}, i_iss.opnd.rs1[31:0]} : i_iss.opnd.rs1;
  assign rs2_c = word ? {{(`EXU_XLEN-32){1'b0}}, i_iss.opnd.rs2[31:0]} : i_iss.opnd.rs2;
  assign imm_c = word ? {{(`EXU_XLEN-32){1'b0}}, i_iss.opnd.imm[31:0]} : i_iss.opnd.imm;

  assign src_a = i_iss.ctrl.src_a_pc ? i_iss.opnd.pc : rs1_c;

  always_comb begin
    case (i_iss.ctrl.src_b)
      SRC_B_IMM:  src_b = imm_c;
      SRC_B_FOUR: src_b = `EXU_XLEN'd4;
      default:    src_b = rs2_c;
    endcase
  end

  assign diff   = src_a - src_b;
  assign o_zero = (diff == '0);
  assign o_less = $signed(src_a) < $signed(src_b);

  assign shamt = word ? {1'b0, src_b[4:0]} : src_b[5:0];
  assign a_sra = word ? {{(`EXU_XLEN-32){src_a[31]}}, src_a[31:0]} : src_a; // sraw needs sign

  always_comb begin
    case (i_iss.ctrl.alu_op)
      ALU_ADD:    res = src_a + src_b;
      ALU_SUB:    res = diff;
      ALU_SLL:    res = src_a << shamt;
      ALU_SLT:    res = {{(`EXU_XLEN-1){1'b0}}, o_less};
      ALU_SLTU:   res = {{(`EXU_XLEN-1){1'b0}}, (src_a < src_b)};
      ALU_XOR:    res = src_a ^ src_b;
      ALU_SRL:    res = src_a >> shamt;
      ALU_SRA:    res = $signed(a_sra) >>> shamt;
      ALU_OR:     res = src_a | src_b;
      ALU_AND:    res = src_a & src_b;
      ALU_COPY_B: res = src_b;
      default:    res = '0;
    endcase
  end

  assign o_result = word ? {{(`EXU_XLEN-32){res[31]}}, res[31:0]} : res;

endmodule

// ==== hw/exu_branch.sv ====
// exu_branch: branch compare and next pc
`include "exu_params.svh"

module exu_branch (
  exu_issue_if.observe         i_iss,
  output logic [`EXU_XLEN-1:0] o_next_pc
);
  import exu_pkg::*;

  logic                 eq;
  logic                 lt;
  logic                 ltu;
  logic                 taken;
  logic [`EXU_XLEN-1:0] pc_imm;
  logic [`EXU_XLEN-1:0] rs1_imm;
  logic [`EXU_XLEN-1:0] pc_seq;

  // own comparator, runs beside the alu
  assign eq  = (i_iss.opnd.rs1 == i_iss.opnd.rs2);
  assign lt  = $signed(i_iss.opnd.rs1) < $signed(i_iss.opnd.rs2);
  assign ltu = i_iss.opnd.rs1 < i_iss.opnd.rs2;

  always_comb begin
    case (i_iss.ctrl.branch)
      BR_JAL:  taken = 1'b1;
      BR_BEQ:  taken = eq;
      BR_BNE:  taken = !eq;
      BR_BLT:  taken = lt;
      BR_BGE:  taken = !lt;
      BR_BLTU: taken = ltu;
      BR_BGEU: taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  assign pc_imm  = i_iss.opnd.pc + i_iss.opnd.imm;
  assign rs1_imm = i_iss.opnd.rs1 + i_iss.opnd.imm;
  assign pc_seq  = i_iss.opnd.pc + `EXU_XLEN'd4;

  always_comb begin
    if (i_iss.ctrl.sys_change_pc) begin
      o_next_pc = i_iss.opnd.sysctr_pc; // ecall/mret target
    end else if (i_iss.ctrl.branch == BR_JALR) begin
      o_next_pc = {rs1_imm[`EXU_XLEN-1:1], 1'b0};
    end else if (taken) begin
      o_next_pc = pc_imm;
    end else begin
      o_next_pc = pc_seq;
    end
  end

endmodule

// ==== lsu/exu_lsu.sv ====
// exu_lsu: AXI4-Lite read master with load data extension
`include "exu_params.svh"

module exu_lsu (
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic                 i_start,
  input  exu_pkg::exu_ctrl_t   i_ctrl,
  input  logic [`EXU_XLEN-1:0] i_addr,
  output logic                 o_load_done,
  output logic [`EXU_XLEN-1:0] o_load_data,
  output logic                 o_load_err,
  input  logic                 i_consume,
  output logic [`EXU_AW-1:0]   o_araddr,
  output logic                 o_arvalid,
  input  logic                 i_arready,
  input  logic [`EXU_XLEN-1:0] i_rdata,
  input  logic [1:0]           i_rresp,
  input  logic                 i_rvalid,
  output logic                 o_rready
);
  import exu_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_DONE
  } lsu_state_e;

  lsu_state_e           state;
  logic [`EXU_AW-1:0]   araddr_q;
  logic [`EXU_XLEN-1:0] rdata_q;
  logic [1:0]           rresp_q;
  logic [`EXU_XLEN-1:0] raw;
  logic [1:0]           resp;
  logic                 r_xfer;

  assign r_xfer = (state == ST_DATA) && i_rvalid;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: if (i_start) state <= ST_ADDR;
        ST_ADDR: if (i_arready) state <= ST_DATA;
        ST_DATA: if (i_rvalid) state <= i_consume ? ST_IDLE : ST_DONE;
        ST_DONE: if (i_consume) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if ((state == ST_IDLE) && i_start) begin
      araddr_q <= i_addr[`EXU_AW-1:0];
    end
    if (r_xfer) begin
      rdata_q <= i_rdata;
      rresp_q <= i_rresp;
    end
  end

  assign o_araddr    = araddr_q;
  assign o_arvalid   = (state == ST_ADDR);
  assign o_rready    = (state == ST_DATA);
  assign o_load_done = r_xfer || (state == ST_DONE);

  // bypass the r beat in its own cycle, held copy after that
  assign raw  = (state == ST_DATA) ? i_rdata : rdata_q;
  assign resp = (state == ST_DATA) ? i_rresp : rresp_q;

  assign o_load_err = (resp != `EXU_RESP_OKAY);

  always_comb begin
    case (i_ctrl.mem_op)
      MEM_LB:  o_load_data = {{(`EXU_XLEN-8){raw[7]}}, raw[7:0]};
      MEM_LBU: o_load_data = {{(`EXU_XLEN-8){1'b0}}, raw[7:0]};
      MEM_LH:  o_load_data = {{(`EXU_XLEN-16){raw[15]}}, raw[15:0]};
      MEM_LHU: o_load_data = {{(`EXU_XLEN-16){1'b0}}, raw[15:0]};
      MEM_LW:  o_load_data = {{(`EXU_XLEN-32){raw[31]}}, raw[31:0]};
      MEM_LWU: o_load_data = {{(`EXU_XLEN-32){1'b0}}, raw[31:0]};
      MEM_LD:  o_load_data = raw;
      default: o_load_data = '0;
    endcase
  end

endmodule

// ==== hw/exu_writeback.sv ====
// exu_writeback: result record assembly, load gating and output slice
`include "exu_params.svh"

module exu_writeback (
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  exu_issue_if.sink            i_iss,
  input  logic [`EXU_XLEN-1:0] i_csr_rdata,
  input  logic [`EXU_XLEN-1:0] i_alu_result,
  input  logic [`EXU_XLEN-1:0] i_next_pc,
  input  logic                 i_load_done,
  input  logic [`EXU_XLEN-1:0] i_load_data,
  input  logic                 i_load_err,
  output logic                 o_lsu_start,
  output logic                 o_lsu_consume,
  output logic                 o_res_valid,
  input  logic                 i_res_ready,
  output exu_pkg::exu_res_t    o_res
);
  import exu_pkg::*;

  logic                 is_load;
  logic                 load_ok;
  logic                 slice_ready;
  logic [`EXU_XLEN-1:0] csr_opnd;
  exu_res_t             res;

  assign is_load = (i_iss.ctrl.mem_op != MEM_NONE);
  assign load_ok = !is_load || i_load_done;

  // hold the request until the load data is in and the slice has room
  assign i_iss.ready   = load_ok && slice_ready;
  assign o_lsu_start   = i_iss.valid && is_load;
  assign o_lsu_consume = i_iss.valid && is_load && i_load_done && slice_ready;

  assign csr_opnd = i_iss.ctrl.sel_zimm ? i_iss.opnd.zimm : i_iss.opnd.rs1;

  always_comb begin
    if (is_load) begin
      res.gpr_wdata = i_load_data;
    end else if (i_iss.ctrl.sel_csr) begin
      res.gpr_wdata = i_csr_rdata; // old csr value to rd
    end else begin
      res.gpr_wdata = i_alu_result;
    end
    case (i_iss.ctrl.csr_op)
      CSR_WRITE: res.csr_wdata = csr_opnd;
      CSR_SET:   res.csr_wdata = i_csr_rdata | csr_opnd;
      default:   res.csr_wdata = '0;
    endcase
    res.next_pc  = i_next_pc;
    res.ebreak   = i_iss.ctrl.ebreak;
    res.illegal  = i_iss.ctrl.illegal;
    res.load_err = is_load && i_load_err;
  end

  exu_pipe_reg #(
    .T (exu_res_t)
  ) u_res_slice (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (i_iss.valid && load_ok),
    .o_ready  (slice_ready),
    .i_data   (res),
    .o_valid  (o_res_valid),
    .i_ready  (i_res_ready),
    .o_data   (o_res)
  );

endmodule

// ==== hw/exu_top.sv ====
// exu_top: execute-and-load stage with request, result and AXI read ports
`include "exu_params.svh"

module exu_top (
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  logic                 i_req_valid,
  output logic                 o_req_ready,
  input  exu_pkg::exu_issue_t  i_req,
  output logic                 o_res_valid,
  input  logic                 i_res_ready,
  output logic [`EXU_XLEN-1:0] o_gpr_wdata,
  output logic [`EXU_XLEN-1:0] o_next_pc,
  output logic [`EXU_XLEN-1:0] o_csr_wdata,
  output logic                 o_ebreak,
  output logic                 o_illegal,
  output logic                 o_load_err,
  output logic [`EXU_AW-1:0]   o_araddr,
  output logic                 o_arvalid,
  input  logic                 i_arready,
  input  logic [`EXU_XLEN-1:0] i_rdata,
  input  logic [1:0]           i_rresp,
  input  logic                 i_rvalid,
  output logic                 o_rready
);
  import exu_pkg::*;

  exu_issue_t           iss_data;
  exu_res_t             res;
  logic [`EXU_XLEN-1:0] alu_result;
  logic [`EXU_XLEN-1:0] next_pc;
  logic                 lsu_start;
  logic                 lsu_consume;
  logic                 load_done;
  logic [`EXU_XLEN-1:0] load_data;
  logic                 load_err;

  exu_issue_if u_iss ();

  exu_pipe_reg #(
    .T (exu_issue_t)
  ) u_req_slice (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (i_req_valid),
    .o_ready  (o_req_ready),
    .i_data   (i_req),
    .o_valid  (u_iss.valid),
    .i_ready  (u_iss.ready),
    .o_data   (iss_data)
  );

  assign u_iss.ctrl = iss_data.ctrl;
  assign u_iss.opnd = iss_data.opnd;

  exu_alu u_alu (
    .i_iss    (u_iss.observe),
    .o_result (alu_result),
    .o_zero   (),
    .o_less   () // branch unit compares on its own
  );

  exu_branch u_branch (
    .i_iss     (u_iss.observe),
    .o_next_pc (next_pc)
  );

  exu_lsu u_lsu (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_start     (lsu_start),
    .i_ctrl      (iss_data.ctrl),
    .i_addr      (alu_result),
    .o_load_done (load_done),
    .o_load_data (load_data),
    .o_load_err  (load_err),
    .i_consume   (lsu_consume),
    .o_araddr    (o_araddr),
    .o_arvalid   (o_arvalid),
    .i_arready   (i_arready),
    .i_rdata     (i_rdata),
    .i_rresp     (i_rresp),
    .i_rvalid    (i_rvalid),
    .o_rready    (o_rready)
  );

  exu_writeback u_wb (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_iss         (u_iss.sink),
    .i_csr_rdata   (iss_data.csr_rdata),
    .i_alu_result  (alu_result),
    .i_next_pc     (next_pc),
    .i_load_done   (load_done),
    .i_load_data   (load_data),
    .i_load_err    (load_err),
    .o_lsu_start   (lsu_start),
    .o_lsu_consume (lsu_consume),
    .o_res_valid   (o_res_valid),
    .i_res_ready   (i_res_ready),
    .o_res         (res)
  );

  assign o_gpr_wdata = res.gpr_wdata;
  assign o_next_pc   = res.next_pc;
  assign o_csr_wdata = res.csr_wdata;
  assign o_ebreak    = res.ebreak;
  assign o_illegal   = res.illegal;
  assign o_load_err  = res.load_err;

endmodule

// ==== verif/tb_exu_top.sv ====
// stimulus, reference model, AXI read memory model and result checks
`include "exu_params.svh"

module tb_exu_top;
  timeunit 1ns;
  timeprecision 100ps;

  import exu_pkg::*;

  localparam int          TMO      = 200;
  localparam logic [31:0] ERR_ADDR = 32'h0000_0ba8; // answers with SLVERR

  logic        i_clk;
  logic        i_arst_n;
  logic        i_req_valid;
  logic        o_req_ready;
  exu_issue_t  i_req;
  logic        o_res_valid;
  logic        i_res_ready;
  logic [63:0] o_gpr_wdata;
  logic [63:0] o_next_pc;
  logic [63:0] o_csr_wdata;
  logic        o_ebreak;
  logic        o_illegal;
  logic        o_load_err;
  logic [31:0] o_araddr;
  logic        o_arvalid;
  logic        i_arready;
  logic [63:0] i_rdata;
  logic [1:0]  i_rresp;
  logic        i_rvalid;
  logic        o_rready;

  exu_res_t    exp_q[$];
  logic [31:0] ar_q[$];
  int          last_wait;
  logic        bp_en;
  int          ar_wait;
  int          r_wait;
  logic        r_pend;
  int          rd_out;
  logic        hold_pend;
  logic [63:0] held_gpr;
  logic [63:0] held_pc;

  exu_top i_dut (.*);

  always #10 i_clk = ~i_clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_field(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp, got);
      fail_run("value mismatch");
    end
  endtask

  function automatic logic [63:0] mem_word(input logic [31:0] a);
    return {a ^ 32'ha5c3_0f69, a * 32'h9e37_79b1 + 32'h1234_5677};
  endfunction

  function automatic logic [31:0] load_addr(input exu_opnd_t o);
    logic [63:0] t;
    t = o.rs1 + o.imm;
    return t[31:0];
  endfunction

  function automatic logic [63:0] load_ext(input mem_op_e op, input logic [63:0] w);
    case (op)
      MEM_LB:  return {{56{w[7]}}, w[7:0]};
      MEM_LBU: return {56'h0, w[7:0]};
      MEM_LH:  return {{48{w[15]}}, w[15:0]};
      MEM_LHU: return {48'h0, w[15:0]};
      MEM_LW:  return {{32{w[31]}}, w[31:0]};
      MEM_LWU: return {32'h0, w[31:0]};
      MEM_LD:  return w;
      default: return 64'h0;
    endcase
  endfunction

  function automatic logic [63:0] cut32(input logic [63:0] v, input logic word);
    return word ? {32'h0, v[31:0]} : v;
  endfunction

  function automatic logic [63:0] alu_model(input exu_ctrl_t c, input exu_opnd_t o);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    logic [5:0]  sh;
    a = c.src_a_pc ? o.pc : cut32(o.rs1, c.word_cut); // pc is never cut
    case (c.src_b)
      SRC_B_IMM:  b = cut32(o.imm, c.word_cut);
      SRC_B_FOUR: b = 64'd4;
      default:    b = cut32(o.rs2, c.word_cut);
    endcase
    sh = c.word_cut ? {1'b0, b[4:0]} : b[5:0];
    case (c.alu_op)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a - b;
      ALU_SLL:  r = a << sh;
      ALU_SLT:  r = {63'h0, $signed(a) < $signed(b)};
      ALU_SLTU: r = {63'h0, a < b};
      ALU_XOR:  r = a ^ b;
      ALU_SRL:  r = a >> sh;
      ALU_SRA: begin
        if (c.word_cut) r = $signed({{32{a[31]}}, a[31:0]}) >>> sh; // sraw
        else r = $signed(a) >>> sh;
      end
      ALU_OR:     r = a | b;
      ALU_AND:    r = a & b;
      ALU_COPY_B: r = b;
      default:    r = 64'h0;
    endcase
    if (c.word_cut) r = {{32{r[31]}}, r[31:0]};
    return r;
  endfunction

  function automatic logic [63:0] pc_model(input exu_ctrl_t c, input exu_opnd_t o);
    logic        take;
    logic [63:0] t;
    case (c.branch)
      BR_JAL:  take = 1'b1;
      BR_BEQ:  take = (o.rs1 == o.rs2);
      BR_BNE:  take = (o.rs1 != o.rs2);
      BR_BLT:  take = ($signed(o.rs1) < $signed(o.rs2));
      BR_BGE:  take = ($signed(o.rs1) >= $signed(o.rs2));
      BR_BLTU: take = (o.rs1 < o.rs2);
      BR_BGEU: take = (o.rs1 >= o.rs2);
      default: take = 1'b0;
    endcase
    t = o.rs1 + o.imm;
    if (c.sys_change_pc) return o.sysctr_pc;
    if (c.branch == BR_JALR) return {t[63:1], 1'b0};
    return take ? o.pc + o.imm : o.pc + 64'd4;
  endfunction

  function automatic exu_res_t res_model(input exu_issue_t q);
    exu_res_t    r;
    logic [63:0] opnd;
    logic [31:0] addr;
    opnd       = q.ctrl.sel_zimm ? q.opnd.zimm : q.opnd.rs1;
    addr       = load_addr(q.opnd);
    r.next_pc  = pc_model(q.ctrl, q.opnd);
    r.ebreak   = q.ctrl.ebreak;
    r.illegal  = q.ctrl.illegal;
    r.load_err = 1'b0;
    if (q.ctrl.mem_op != MEM_NONE) begin
      r.gpr_wdata = load_ext(q.ctrl.mem_op, mem_word(addr));
      r.load_err  = (addr == ERR_ADDR);
    end else if (q.ctrl.sel_csr) begin
      r.gpr_wdata = q.csr_rdata;
    end else begin
      r.gpr_wdata = alu_model(q.ctrl, q.opnd);
    end
    case (q.ctrl.csr_op)
      CSR_WRITE: r.csr_wdata = opnd;
      CSR_SET:   r.csr_wdata = q.csr_rdata | opnd;
      default:   r.csr_wdata = 64'h0;
    endcase
    return r;
  endfunction

  function automatic branch_e br_of(input int unsigned k);
    case (k)
      1:       return BR_JAL;
      2:       return BR_JALR;
      3:       return BR_BEQ;
      4:       return BR_BNE;
      5:       return BR_BLT;
      6:       return BR_BGE;
      7:       return BR_BLTU;
      8:       return BR_BGEU;
      default: return BR_NONE;
    endcase
  endfunction

  function automatic exu_issue_t base_req();
    exu_issue_t  q;
    logic [11:0] imm12;
    q                = '0;
    q.ctrl.mem_op    = MEM_NONE;
    imm12            = 12'($urandom);
    q.opnd.rs1       = {$urandom, $urandom};
    q.opnd.rs2       = {$urandom, $urandom};
    q.opnd.imm       = {{52{imm12[11]}}, imm12};
    q.opnd.pc        = {32'h0, $urandom & 32'hffff_fffc};
    q.opnd.sysctr_pc = {32'h0, $urandom & 32'hffff_fffc};
    q.opnd.zimm      = {59'h0, 5'($urandom)};
    q.csr_rdata      = {$urandom, $urandom};
    return q;
  endfunction

  function automatic exu_issue_t rand_req();
    exu_issue_t q;
    q = base_req();
    case ($urandom_range(0, 3))
      0: begin
        q.ctrl.alu_op   = alu_op_e'(5'($urandom_range(0, 10)));
        q.ctrl.src_a_pc = 1'($urandom);
        q.ctrl.src_b    = src_b_e'(2'($urandom_range(0, 2)));
        q.ctrl.word_cut = 1'($urandom);
        q.ctrl.branch   = br_of($urandom_range(0, 8));
      end
      1: begin
        q.ctrl.mem_op = mem_op_e'(3'($urandom_range(0, 6)));
        q.ctrl.src_b  = SRC_B_IMM;
        if ($urandom_range(0, 7) == 0) q.opnd.rs1 = {$urandom, ERR_ADDR - q.opnd.imm[31:0]};
      end
      2: begin
        q.ctrl.sel_csr  = 1'b1;
        q.ctrl.csr_op   = csr_op_e'(2'($urandom_range(0, 2)));
        q.ctrl.sel_zimm = 1'($urandom);
      end
      default: begin
        q.ctrl.ebreak        = 1'($urandom);
        q.ctrl.illegal       = 1'($urandom);
        q.ctrl.sys_change_pc = 1'($urandom);
      end
    endcase
    return q;
  endfunction

  // drive one request, return at its accepting edge
  task automatic send_req(input exu_issue_t q);
    int n;
    i_req_valid <= 1'b1;
    i_req       <= q;
    exp_q.push_back(res_model(q));
    if (q.ctrl.mem_op != MEM_NONE) ar_q.push_back(load_addr(q.opnd));
    n = 0;
    do begin
      @(posedge i_clk);
      n++;
      if (n > TMO) fail_run("timeout waiting for o_req_ready");
    end while (!o_req_ready);
    last_wait = n;
  endtask

  task automatic wait_drain();
    int n;
    i_req_valid <= 1'b0;
    n = 0;
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
      n++;
      if (n > TMO) fail_run("timeout waiting for outstanding results");
    end
    @(posedge i_clk);
  endtask

  task automatic check_latency(input exu_issue_t q);
    int n;
    send_req(q);
    i_req_valid <= 1'b0;
    n = 0;
    do begin
      @(posedge i_clk);
      n++;
      if (n > TMO) fail_run("timeout waiting for o_res_valid");
    end while (!o_res_valid);
    assert (n == 2) else begin
      $display("ERR t=%0t o_res_valid latency exp=2 got=%0d", $time, n);
      fail_run("result latency mismatch");
    end
  endtask

  // result monitor, compares against the model queue
  always @(posedge i_clk) begin
    exu_res_t e;
    if (i_arst_n && o_res_valid && i_res_ready) begin
      if (exp_q.size() == 0) fail_run("result transfer with no request outstanding");
      e = exp_q.pop_front();
      check_field("o_gpr_wdata", e.gpr_wdata, o_gpr_wdata);
      check_field("o_next_pc", e.next_pc, o_next_pc);
      check_field("o_csr_wdata", e.csr_wdata, o_csr_wdata);
      check_field("o_ebreak", 64'(e.ebreak), 64'(o_ebreak));
      check_field("o_illegal", 64'(e.illegal), 64'(o_illegal));
      check_field("o_load_err", 64'(e.load_err), 64'(o_load_err));
    end
  end

  // a stalled result must stay put
  always @(posedge i_clk) begin
    if (i_arst_n) begin
      if (hold_pend) begin
        assert (o_res_valid) else fail_run("o_res_valid dropped before the result was taken");
        check_field("o_gpr_wdata", held_gpr, o_gpr_wdata);
        check_field("o_next_pc", held_pc, o_next_pc);
      end
      hold_pend = o_res_valid && !i_res_ready;
      held_gpr  = o_gpr_wdata;
      held_pc   = o_next_pc;
    end
  end

  always @(posedge i_clk) begin
    i_res_ready <= bp_en ? ($urandom_range(0, 2) != 0) : 1'b1;
  end

  // AXI4-Lite read slave, random AR and R delays
  always @(posedge i_clk) begin
    logic [31:0] exp_addr;
    if (i_arst_n) begin
      if (i_rvalid && o_rready) begin
        i_rvalid <= 1'b0;
        rd_out = rd_out - 1;
      end
      if (o_arvalid && i_arready) begin
        assert (rd_out == 0) else fail_run("second AXI read issued while one is outstanding");
        assert (ar_q.size() != 0) else fail_run("AR transfer with no load pending");
        exp_addr = ar_q.pop_front();
        check_field("o_araddr", 64'(exp_addr), 64'(o_araddr));
        i_arready <= 1'b0;
        i_rdata   <= mem_word(o_araddr);
        i_rresp   <= (o_araddr == ERR_ADDR) ? 2'b10 : `EXU_RESP_OKAY;
        rd_out = rd_out + 1;
        r_wait = $urandom_range(0, 3);
        r_pend = 1'b1;
      end else begin
        if (o_arvalid && !i_arready) begin
          if (ar_wait == 0) i_arready <= 1'b1;
          else ar_wait = ar_wait - 1;
        end else if (!o_arvalid) begin
          ar_wait = $urandom_range(0, 3);
        end
        if (r_pend) begin
          if (r_wait == 0) begin
            i_rvalid <= 1'b1;
            r_pend = 1'b0;
          end else begin
            r_wait = r_wait - 1;
          end
        end
      end
    end
  end

  initial begin
    exu_issue_t q;
    void'($urandom(26486));
    i_clk       = 1'b0;
    i_arst_n    = 1'b0;
    i_req_valid = 1'b0;
    i_req       = '0;
    i_res_ready = 1'b1;
    i_arready   = 1'b0;
    i_rdata     = 64'h0;
    i_rresp     = 2'b00;
    i_rvalid    = 1'b0;
    bp_en       = 1'b0;
    ar_wait     = 0;
    r_wait      = 0;
    r_pend      = 1'b0;
    rd_out      = 0;
    hold_pend   = 1'b0;
    repeat (10) @(posedge i_clk);
    i_arst_n <= 1'b1;
    @(posedge i_clk);
    check_field("o_res_valid", 64'd0, 64'(o_res_valid));
    check_field("o_arvalid", 64'd0, 64'(o_arvalid));
    check_field("o_rready", 64'd0, 64'(o_rready));
    check_field("o_req_ready", 64'd1, 64'(o_req_ready));

    // every alu op, reg/imm and word forms, back to back
    for (int i = 0; i <= 10; i++) begin
      for (int s = 0; s < 2; s++) begin
        for (int w = 0; w < 2; w++) begin
          q = base_req();
          q.ctrl.alu_op   = alu_op_e'(5'(i));
          q.ctrl.src_b    = (s == 1) ? SRC_B_IMM : SRC_B_RS2;
          q.ctrl.word_cut = 1'(w);
          send_req(q);
          assert (last_wait == 1) else fail_run("back-to-back request was stalled");
        end
      end
    end
    wait_drain();
    repeat (3) check_latency(base_req());

    for (int k = 0; k <= 8; k++) begin
      for (int e = 0; e < 2; e++) begin
        q = base_req();
        q.ctrl.branch = br_of(k);
        if (e == 1) q.opnd.rs2 = q.opnd.rs1; // equal operands
        if (q.ctrl.branch == BR_JAL || q.ctrl.branch == BR_JALR) begin
          q.ctrl.src_a_pc = 1'b1; // link value pc+4
          q.ctrl.src_b    = SRC_B_FOUR;
          q.opnd.imm[0]   = 1'(e);
        end
        send_req(q);
      end
    end
    q = base_req();
    q.ctrl.branch        = BR_JAL;
    q.ctrl.sys_change_pc = 1'b1;
    send_req(q);
    wait_drain();

    for (int m = 0; m <= 6; m++) begin
      repeat (2) begin
        q = base_req();
        q.ctrl.mem_op = mem_op_e'(3'(m));
        q.ctrl.src_b  = SRC_B_IMM;
        send_req(q);
      end
    end
    q = base_req();
    q.ctrl.mem_op = MEM_LD;
    q.ctrl.src_b  = SRC_B_IMM;
    q.opnd.rs1    = {$urandom, ERR_ADDR};
    q.opnd.imm    = 64'h0;
    send_req(q);
    wait_drain();

    for (int c = 1; c <= 2; c++) begin
      for (int z = 0; z < 2; z++) begin
        q = base_req();
        q.ctrl.sel_csr  = 1'b1;
        q.ctrl.csr_op   = csr_op_e'(2'(c));
        q.ctrl.sel_zimm = 1'(z);
        send_req(q);
      end
    end
    q = base_req();
    q.ctrl.ebreak = 1'b1;
    send_req(q);
    q = base_req();
    q.ctrl.illegal = 1'b1;
    send_req(q);
    wait_drain();

    // mixed traffic under random back-pressure
    bp_en = 1'b1;
    for (int i = 0; i < 150; i++) begin
      send_req(rand_req());
      if ($urandom_range(0, 3) == 0) begin
        i_req_valid <= 1'b0;
        @(posedge i_clk);
      end
    end
    wait_drain();
    bp_en = 1'b0;
    repeat (2) @(posedge i_clk);

    if (exp_q.size() != 0 || ar_q.size() != 0) begin
      fail_run("results or AXI reads still pending at end of run");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== sim.f ====
+incdir+common
common/exu_pkg.sv
common/exu_issue_if.sv
hw/exu_pipe_reg.sv
hw/exu_alu.sv
hw/exu_branch.sv
lsu/exu_lsu.sv
hw/exu_writeback.sv
hw/exu_top.sv
verif/tb_exu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_exu_top -f sim.f -o tb_exu_top > sim.log 2>&1 \
  && ./obj_dir/tb_exu_top >> sim.log 2>&1
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "no pass result in sim.log"; exit 1; }
echo "simulation passed"
